//--- common/sru_pkg.sv
`default_nettype none

package sru_pkg;

    localparam int XLEN   = 32;
    localparam int CODE_W = 4;

    // interrupt bit positions in mie and mip.
    localparam int MSIP_BIT = 3;
    localparam int MTIP_BIT = 7;
    localparam int MEIP_BIT = 11;

    // mstatus field positions.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MSTATUS_MPRV_BIT = 17;

    // interrupt cause codes match their pending bit.
    localparam logic [CODE_W-1:0] IRQ_CODE_MSI = CODE_W'(MSIP_BIT);
    localparam logic [CODE_W-1:0] IRQ_CODE_MTI = CODE_W'(MTIP_BIT);
    localparam logic [CODE_W-1:0] IRQ_CODE_MEI = CODE_W'(MEIP_BIT);

    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } prv_e;

    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344
    } csr_addr_e;

    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
    } csr_we_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_bits_t;

    typedef struct packed {
        logic mie;
        logic mpie;
        prv_e mpp;
        logic mprv;
    } mstatus_t;

    typedef struct packed {
        logic  trap_en;
        xlen_t epc;
        xlen_t cause;
        xlen_t tval;
    } trap_req_t;

    // event chosen by the arbiter for this cycle.
    typedef struct packed {
        logic              take;
        logic [CODE_W-1:0] code;
        logic              is_irq;
        xlen_t             epc;
        xlen_t             tval;
        logic              mret;
    } trap_evt_t;

    typedef struct packed {
        prv_e              prv;
        mstatus_t          mstatus;
        irq_bits_t         mie;
        xlen_t             mtvec;
        xlen_t             mscratch;
        xlen_t             mepc;
        logic              mcause_int;
        logic [CODE_W-1:0] mcause_code;
        xlen_t             mtval;
    } csr_state_t;

endpackage

`default_nettype wire

//--- hdl/csr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module csr_decode (
    input  logic                csr_wr,
    input  sru_pkg::csr_addr_e  csr_waddr,
    output sru_pkg::csr_we_t    we
);

    import sru_pkg::*;

    always_comb begin
        we = '0;
        if (csr_wr) begin
            case (csr_waddr)
                CSR_MSTATUS: begin
                    we.mstatus = 1'b1;
                end
                CSR_MIE: begin
                    we.mie = 1'b1;
                end
                CSR_MTVEC: begin
                    we.mtvec = 1'b1;
                end
                CSR_MSCRATCH: begin
                    we.mscratch = 1'b1;
                end
                CSR_MEPC: begin
                    we.mepc = 1'b1;
                end
                CSR_MCAUSE: begin
                    we.mcause = 1'b1;
                end
                CSR_MTVAL: begin
                    we.mtval = 1'b1;
                end
                // mip is read-only; anything else is ignored.
                default: begin
                    we = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  logic                 clk,
    input  logic                 srstn,
    input  sru_pkg::csr_we_t     we,
    input  sru_pkg::xlen_t       wdata,
    input  sru_pkg::trap_evt_t   evt,
    output sru_pkg::csr_state_t  state
);

    import sru_pkg::*;

    prv_e              prv_q;
    mstatus_t          mstatus_q;
    irq_bits_t         mie_q;
    xlen_t             mtvec_q;
    xlen_t             mscratch_q;
    xlen_t             mepc_q;
    logic              mcause_int_q;
    logic [CODE_W-1:0] mcause_code_q;
    xlen_t             mtval_q;
    logic              mpp_legal;

    // only U (00) and M (11) are legal for mpp.
    assign mpp_legal = wdata[MSTATUS_MPP_LSB] == wdata[MSTATUS_MPP_LSB+1];

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            prv_q     <= PRV_M;
            mstatus_q <= '0;
        end else if (evt.take) begin
            prv_q          <= PRV_M;
            mstatus_q.mpp  <= prv_q;
            mstatus_q.mpie <= mstatus_q.mie;
            mstatus_q.mie  <= 1'b0;
        end else if (evt.mret) begin
            prv_q          <= mstatus_q.mpp;
            mstatus_q.mpp  <= PRV_U;
            mstatus_q.mie  <= mstatus_q.mpie;
            mstatus_q.mpie <= 1'b1;
        end else if (we.mstatus) begin
            mstatus_q.mie  <= wdata[MSTATUS_MIE_BIT];
            mstatus_q.mpie <= wdata[MSTATUS_MPIE_BIT];
            mstatus_q.mprv <= wdata[MSTATUS_MPRV_BIT];
            if (mpp_legal) begin
                mstatus_q.mpp <= prv_e'(wdata[MSTATUS_MPP_LSB +: 2]);
            end
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mie_q <= '0;
        end else if (we.mie) begin
            mie_q.meip <= wdata[MEIP_BIT];
            mie_q.mtip <= wdata[MTIP_BIT];
            mie_q.msip <= wdata[MSIP_BIT];
        end
    end

    // bit 1 is reserved in mtvec mode.
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mtvec_q <= '0;
        end else if (we.mtvec) begin
            mtvec_q <= wdata & ~xlen_t'(2);
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mscratch_q <= '0;
        end else if (we.mscratch) begin
            mscratch_q <= wdata;
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mepc_q <= '0;
        end else if (evt.take) begin
            mepc_q <= evt.epc;
        end else if (we.mepc) begin
            mepc_q <= {wdata[XLEN-1:1], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mcause_int_q  <= 1'b0;
            mcause_code_q <= '0;
        end else if (evt.take) begin
            mcause_int_q  <= evt.is_irq;
            mcause_code_q <= evt.code;
        end else if (we.mcause) begin
            mcause_int_q  <= wdata[XLEN-1];
            mcause_code_q <= wdata[CODE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mtval_q <= '0;
        end else if (evt.take) begin
            mtval_q <= evt.tval;
        end else if (we.mtval) begin
            mtval_q <= wdata;
        end
    end

    assign state = '{
        prv:         prv_q,
        mstatus:     mstatus_q,
        mie:         mie_q,
        mtvec:       mtvec_q,
        mscratch:    mscratch_q,
        mepc:        mepc_q,
        mcause_int:  mcause_int_q,
        mcause_code: mcause_code_q,
        mtval:       mtval_q
    };

endmodule

`default_nettype wire

//--- hdl/csr_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux (
    input  sru_pkg::csr_addr_e   raddr,
    input  sru_pkg::csr_state_t  state,
    input  sru_pkg::irq_bits_t   mip,
    output sru_pkg::xlen_t       rdata
);

    import sru_pkg::*;

    xlen_t mstatus_img;
    xlen_t mcause_img;

    // places the three interrupt bits at their architectural positions.
    function automatic xlen_t irq_image(input irq_bits_t b);
        xlen_t img;
        img           = '0;
        img[MEIP_BIT] = b.meip;
        img[MTIP_BIT] = b.mtip;
        img[MSIP_BIT] = b.msip;
        return img;
    endfunction

    always_comb begin
        mstatus_img                         = '0;
        mstatus_img[MSTATUS_MIE_BIT]        = state.mstatus.mie;
        mstatus_img[MSTATUS_MPIE_BIT]       = state.mstatus.mpie;
        mstatus_img[MSTATUS_MPP_LSB +: 2]   = state.mstatus.mpp;
        mstatus_img[MSTATUS_MPRV_BIT]       = state.mstatus.mprv;
    end

    assign mcause_img = {state.mcause_int, {(XLEN-CODE_W-1){1'b0}}, state.mcause_code};

    always_comb begin
        case (raddr)
            CSR_MSTATUS:  rdata = mstatus_img;
            CSR_MIE:      rdata = irq_image(state.mie);
            CSR_MTVEC:    rdata = state.mtvec;
            CSR_MSCRATCH: rdata = state.mscratch;
            CSR_MEPC:     rdata = state.mepc;
            CSR_MCAUSE:   rdata = mcause_img;
            CSR_MTVAL:    rdata = state.mtval;
            CSR_MIP:      rdata = irq_image(mip);
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/sru_top.sv
`timescale 1ns/1ns
`default_nettype none

module sru_top (
    input  logic                clk,
    input  logic                srstn,

    // csr access
    input  logic                csr_wr,
    input  sru_pkg::csr_addr_e  csr_waddr,
    input  sru_pkg::xlen_t      csr_wdata,
    input  sru_pkg::csr_addr_e  csr_raddr,
    output sru_pkg::xlen_t      csr_rdata,

    // pipeline events
    input  sru_pkg::trap_req_t  trap,
    input  logic                mret,

    // interrupt pins, asynchronous.
    input  logic                ext_msip,
    input  logic                ext_mtip,
    input  logic                ext_meip,

    output sru_pkg::prv_e       prv,
    output sru_pkg::prv_e       mpp,
    output logic                mprv,
    output logic                wakeup,
    output logic                irq_trigger,
    output logic                eret_en,
    output sru_pkg::xlen_t      trap_vec,
    output sru_pkg::xlen_t      ret_epc,
    output sru_pkg::xlen_t      cause,
    output sru_pkg::xlen_t      tval
);

    import sru_pkg::*;

    csr_we_t    we;
    trap_evt_t  evt;
    irq_bits_t  mip;
    csr_state_t state;

    csr_decode decode_inst (
        .csr_wr    (csr_wr),
        .csr_waddr (csr_waddr),
        .we        (we)
    );

    trap_arbiter arbiter_inst (
        .clk         (clk),
        .srstn       (srstn),
        .ext_msip    (ext_msip),
        .ext_mtip    (ext_mtip),
        .ext_meip    (ext_meip),
        .trap        (trap),
        .mret        (mret),
        .state       (state),
        .evt         (evt),
        .mip         (mip),
        .irq_trigger (irq_trigger),
        .wakeup      (wakeup),
        .eret_en     (eret_en),
        .trap_vec    (trap_vec),
        .ret_epc     (ret_epc),
        .cause       (cause),
        .tval        (tval)
    );

    csr_file file_inst (
        .clk   (clk),
        .srstn (srstn),
        .we    (we),
        .wdata (csr_wdata),
        .evt   (evt),
        .state (state)
    );

    csr_read_mux read_inst (
        .raddr (csr_raddr),
        .state (state),
        .mip   (mip),
        .rdata (csr_rdata)
    );

    assign prv  = state.prv;
    assign mpp  = state.mstatus.mpp;
    assign mprv = state.mstatus.mprv;

endmodule

`default_nettype wire

//--- hdl/trap_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module trap_arbiter (
    input  logic                 clk,
    input  logic                 srstn,
    input  logic                 ext_msip,
    input  logic                 ext_mtip,
    input  logic                 ext_meip,
    input  sru_pkg::trap_req_t   trap,
    input  logic                 mret,
    input  sru_pkg::csr_state_t  state,
    output sru_pkg::trap_evt_t   evt,
    output sru_pkg::irq_bits_t   mip,
    output logic                 irq_trigger,
    output logic                 wakeup,
    output logic                 eret_en,
    output sru_pkg::xlen_t       trap_vec,
    output sru_pkg::xlen_t       ret_epc,
    output sru_pkg::xlen_t       cause,
    output sru_pkg::xlen_t       tval
);

    import sru_pkg::*;

    irq_bits_t         pin_s1;
    irq_bits_t         pend_en;
    logic              glb_en;
    logic              irq_take;
    logic [CODE_W-1:0] irq_code;
    xlen_t             vec_off;

    // two-flop synchronizer for the asynchronous pins.
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            pin_s1 <= '0;
            mip    <= '0;
        end else begin
            pin_s1 <= '{meip: ext_meip, mtip: ext_mtip, msip: ext_msip};
            mip    <= pin_s1;
        end
    end

    assign pend_en = mip & state.mie;
    assign glb_en  = (state.prv == PRV_U) || (state.prv == PRV_M && state.mstatus.mie);

    // a synchronous trap always wins over an interrupt.
    assign irq_take    = glb_en && (|pend_en) && !trap.trap_en;
    assign irq_trigger = irq_take;
    assign wakeup      = |pend_en;

    // fixed priority: external, then software, then timer.
    always_comb begin
        if (pend_en.meip) begin
            irq_code = IRQ_CODE_MEI;
        end else if (pend_en.msip) begin
            irq_code = IRQ_CODE_MSI;
        end else begin
            irq_code = IRQ_CODE_MTI;
        end
    end

    always_comb begin
        if (trap.trap_en) begin
            cause = trap.cause;
        end else if (irq_take) begin
            cause = {1'b1, {(XLEN-CODE_W-1){1'b0}}, irq_code};
        end else begin
            cause = '0;
        end
    end

    assign tval = trap.trap_en ? trap.tval : '0;

    // vectored mode only offsets interrupts.
    assign vec_off  = (irq_take && state.mtvec[0]) ?
                      {{(XLEN-CODE_W-2){1'b0}}, irq_code, 2'b00} : '0;
    assign trap_vec = {state.mtvec[XLEN-1:2], 2'b00} + vec_off;

    assign eret_en = mret && !trap.trap_en;
    assign ret_epc = state.mepc;

    assign evt = '{
        take:   trap.trap_en || irq_take,
        code:   trap.trap_en ? trap.cause[CODE_W-1:0] : irq_code,
        is_irq: trap.trap_en ? trap.cause[XLEN-1] : 1'b1,
        epc:    trap.epc,
        tval:   tval,
        mret:   eret_en
    };

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module sru_tb -f sources.f -o sru_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sru_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1

//--- sources.f
common/sru_pkg.sv
hdl/csr_decode.sv
hdl/trap_arbiter.sv
hdl/csr_file.sv
hdl/csr_read_mux.sv
hdl/sru_top.sv
test/sru_properties.sv
test/sru_tb.sv

//--- test/sru_properties.sv
`timescale 1ns/1ns
`default_nettype none

module sru_properties (
    input logic                clk,
    input logic                srstn,
    input sru_pkg::trap_req_t  trap,
    input logic                irq_trigger,
    input logic                eret_en,
    input logic                wakeup,
    input sru_pkg::prv_e       prv
);

    import sru_pkg::*;

    // a synchronous trap blocks both the interrupt and mret.
    trap_blocks_events: assert property (
        @(posedge clk) disable iff (!srstn)
        trap.trap_en |-> !irq_trigger && !eret_en
    ) else $error("irq_trigger or eret_en high in a cycle with trap_en");

    irq_implies_wakeup: assert property (
        @(posedge clk) disable iff (!srstn)
        irq_trigger |-> wakeup
    ) else $error("irq_trigger high while wakeup is low");

    trap_enters_m: assert property (
        @(posedge clk) disable iff (!srstn)
        trap.trap_en |=> prv == PRV_M
    ) else $error("prv is not M in the cycle after trap_en");

endmodule

bind sru_top sru_properties props_inst (
    .clk         (clk),
    .srstn       (srstn),
    .trap        (trap),
    .irq_trigger (irq_trigger),
    .eret_en     (eret_en),
    .wakeup      (wakeup),
    .prv         (prv)
);

`default_nettype wire

//--- test/sru_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sru_tb;

    import sru_pkg::*;

    logic       clk;
    logic       srstn;
    logic       csr_wr;
    csr_addr_e  csr_waddr;
    xlen_t      csr_wdata;
    csr_addr_e  csr_raddr;
    xlen_t      csr_rdata;
    trap_req_t  trap;
    logic       mret;
    logic       ext_msip;
    logic       ext_mtip;
    logic       ext_meip;
    prv_e       prv;
    prv_e       mpp;
    logic       mprv;
    logic       wakeup;
    logic       irq_trigger;
    logic       eret_en;
    xlen_t      trap_vec;
    xlen_t      ret_epc;
    xlen_t      cause;
    xlen_t      tval;

    // reference model; interrupt sets are ordered {meip, mtip, msip}.
    logic [1:0]  m_prv;
    logic        m_mie;
    logic        m_mpie;
    logic [1:0]  m_mpp;
    logic        m_mprv;
    logic [2:0]  m_en;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic        m_mcause_int;
    logic [3:0]  m_mcause_code;
    logic [31:0] m_mtval;
    logic [2:0]  m_s1;
    logic [2:0]  m_s2;

    logic [31:0] lfsr;
    logic        irq_seen;
    int          errors;
    int          checks;
    int          tests;

    sru_top sru_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic csr_addr_e addr_at(input int i);
        case (i)
            0: return CSR_MSTATUS;
            1: return CSR_MIE;
            2: return CSR_MTVEC;
            3: return CSR_MSCRATCH;
            4: return CSR_MEPC;
            5: return CSR_MCAUSE;
            6: return CSR_MTVAL;
            7: return CSR_MIP;
            default: return csr_addr_e'(12'h7c0);
        endcase
    endfunction

    // one in eight picks an arbitrary address that is mostly unmapped.
    function automatic csr_addr_e rand_addr();
        if (rand_bits(3) == 0) begin
            return csr_addr_e'(12'(rand_bits(12)));
        end
        return addr_at(int'(rand_bits(3)));
    endfunction

    function automatic logic [2:0] m_pend();
        return m_s2 & m_en;
    endfunction

    function automatic logic m_irq();
        return (m_prv == 2'd0 || (m_prv == 2'd3 && m_mie)) && (|m_pend()) && !trap.trap_en;
    endfunction

    function automatic logic [3:0] m_code();
        logic [2:0] p;
        p = m_pend();
        if (p[2]) begin
            return 4'd11;
        end else if (p[0]) begin
            return 4'd3;
        end
        return 4'd7;
    endfunction

    function automatic logic [31:0] irq_img(input logic [2:0] b);
        logic [31:0] img;
        img = '0;
        img[11] = b[2];
        img[7] = b[1];
        img[3] = b[0];
        return img;
    endfunction

    function automatic logic [31:0] model_read(input csr_addr_e a);
        case (a)
            CSR_MSTATUS: return {14'd0, m_mprv, 4'd0, m_mpp, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
            CSR_MIE: return irq_img(m_en);
            CSR_MTVEC: return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC: return m_mepc;
            CSR_MCAUSE: return {m_mcause_int, 27'd0, m_mcause_code};
            CSR_MTVAL: return m_mtval;
            CSR_MIP: return irq_img(m_s2);
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_comb();
        logic [31:0] exp_cause;
        logic [31:0] exp_vec;
        logic        take;
        take = m_irq();
        exp_vec = {m_mtvec[31:2], 2'b00};
        exp_cause = 32'd0;
        if (trap.trap_en) begin
            exp_cause = trap.cause;
        end else if (take) begin
            exp_cause = {1'b1, 27'd0, m_code()};
            if (m_mtvec[0]) begin
                exp_vec += {26'd0, m_code(), 2'b00};
            end
        end
        check_eq(32'(irq_trigger), 32'(take), "irq_trigger");
        check_eq(32'(wakeup), 32'(|m_pend()), "wakeup");
        check_eq(32'(eret_en), 32'(mret && !trap.trap_en), "eret_en");
        check_eq(trap_vec, exp_vec, "trap_vec");
        check_eq(cause, exp_cause, "cause");
        check_eq(tval, trap.trap_en ? trap.tval : 32'd0, "tval");
        check_eq(ret_epc, m_mepc, "ret_epc");
        check_eq(32'(prv), 32'(m_prv), "prv");
        check_eq(32'(mpp), 32'(m_mpp), "mpp");
        check_eq(32'(mprv), 32'(m_mprv), "mprv");
        check_eq(csr_rdata, model_read(csr_raddr), $sformatf("csr_rdata at %h", csr_raddr));
    endtask

    // trap or interrupt beats mret, and mret beats writes at a rising edge.
    task automatic model_edge();
        logic        take;
        logic [3:0]  code;
        logic [31:0] wd;
        take = trap.trap_en || m_irq();
        code = m_code();
        wd = csr_wdata;
        if (take) begin
            m_mepc = trap.epc;
            m_mcause_int = trap.trap_en ? trap.cause[31] : 1'b1;
            m_mcause_code = trap.trap_en ? trap.cause[3:0] : code;
            m_mtval = trap.trap_en ? trap.tval : 32'd0;
            m_mpp = m_prv;
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_prv = 2'd3;
        end else if (mret) begin
            m_prv = m_mpp;
            m_mpp = 2'd0;
            m_mie = m_mpie;
            m_mpie = 1'b1;
        end else if (csr_wr && csr_waddr == CSR_MSTATUS) begin
            m_mie = wd[3];
            m_mpie = wd[7];
            m_mprv = wd[17];
            if (wd[12] == wd[11]) begin
                m_mpp = wd[12:11];
            end
        end
        if (csr_wr) begin
            case (csr_waddr)
                CSR_MIE: m_en = {wd[11], wd[7], wd[3]};
                CSR_MTVEC: m_mtvec = wd & ~32'd2;
                CSR_MSCRATCH: m_mscratch = wd;
                CSR_MEPC: if (!take) m_mepc = {wd[31:1], 1'b0};
                CSR_MCAUSE: if (!take) {m_mcause_int, m_mcause_code} = {wd[31], wd[3:0]};
                CSR_MTVAL: if (!take) m_mtval = wd;
                default: ;
            endcase
        end
        m_s2 = m_s1;
        m_s1 = {ext_meip, ext_mtip, ext_msip};
    endtask

    // called just after a falling edge; returns just after the next one.
    task automatic tick();
        #10;
        check_comb();
        irq_seen = irq_trigger;
        @(posedge clk);
        model_edge();
        @(negedge clk);
    endtask

    task automatic csr_write(input csr_addr_e a, input logic [31:0] d);
        csr_wr = 1'b1;
        csr_waddr = a;
        csr_wdata = d;
        tick();
        csr_wr = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_e a);
        csr_raddr = a;
        tick();
    endtask

    // random mstatus with a legal mpp, then mret into that mode.
    task automatic random_prv();
        logic [31:0] d;
        d = rand_bits(32);
        d[12] = d[11];
        csr_write(CSR_MSTATUS, d);
        mret = 1'b1;
        tick();
        mret = 1'b0;
    endtask

    task automatic random_trap();
        trap.trap_en = 1'b1;
        trap.epc = rand_bits(32);
        trap.cause = rand_bits(32);
        trap.tval = rand_bits(32);
    endtask

    task automatic wait_irq(input int limit, input logic want_irq, input logic suppress);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < limit) begin
            csr_raddr = CSR_MIP;
            if (suppress && m_irq()) begin
                random_trap();
                done = 1'b1;
            end
            tick();
            trap = '0;
            done = done || irq_seen;
            n++;
        end
        if (want_irq && !done) begin
            errors++;
            $display("irq_trigger did not rise within %0d cycles with an enabled interrupt pending",
                     limit);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        logic [31:0] d;
        logic        want_irq;
        csr_addr_e   a;
        lfsr = 32'h33b21cd5;
        errors = 0;
        checks = 0;
        tests = 0;
        srstn = 1'b0;
        csr_wr = 1'b0;
        csr_waddr = CSR_MSTATUS;
        csr_wdata = '0;
        csr_raddr = CSR_MSTATUS;
        trap = '0;
        mret = 1'b0;
        {ext_meip, ext_mtip, ext_msip} = 3'b000;
        {m_mie, m_mpie, m_mpp, m_mprv, m_en, m_s1, m_s2} = '0;
        {m_mtvec, m_mscratch, m_mepc, m_mtval, m_mcause_int, m_mcause_code} = '0;
        m_prv = 2'd3;
        repeat (10) @(posedge clk);
        @(negedge clk);
        srstn = 1'b1;

        check_eq(32'(prv), 32'd3, "prv after reset");
        for (int i = 0; i < 9; i++) begin
            csr_read(addr_at(i));
        end
        end_test("reset");

        for (int i = 0; i < 40; i++) begin
            a = rand_addr();
            csr_write(a, rand_bits(32));
            csr_read(a);
        end
        // a write to mip must leave every register untouched.
        csr_write(CSR_MIP, 32'hffff_ffff);
        for (int i = 0; i < 9; i++) begin
            csr_read(addr_at(i));
        end
        end_test("csr_rw");

        for (int i = 0; i < 12; i++) begin
            random_prv();
            random_trap();
            csr_wr = 1'(rand_bits(1));
            csr_waddr = rand_addr();
            csr_wdata = rand_bits(32);
            tick();
            trap = '0;
            csr_wr = 1'b0;
            csr_read(CSR_MEPC);
            csr_read(CSR_MCAUSE);
            csr_read(CSR_MTVAL);
            csr_read(CSR_MSTATUS);
        end
        end_test("trap");

        for (int i = 0; i < 10; i++) begin
            csr_write(CSR_MEPC, rand_bits(32));
            d = rand_bits(32);
            d[12] = d[11];
            csr_write(CSR_MSTATUS, d);
            mret = 1'b1;
            tick();
            mret = 1'b0;
            csr_read(CSR_MSTATUS);
        end
        end_test("mret");

        for (int i = 0; i < 24; i++) begin
            csr_write(CSR_MTVEC, rand_bits(32));
            csr_write(CSR_MIE, rand_bits(32));
            random_prv();
            {ext_meip, ext_mtip, ext_msip} = 3'(rand_bits(3));
            want_irq = (|({ext_meip, ext_mtip, ext_msip} & m_en)) && (m_prv == 2'd0 || m_mie);
            wait_irq(8, want_irq, rand_bits(2) == 0);
            {ext_meip, ext_mtip, ext_msip} = 3'b000;
            repeat (3) csr_read(CSR_MIP);
        end
        end_test("interrupt");

        for (int i = 0; i < 300; i++) begin
            csr_wr = 1'(rand_bits(1));
            csr_waddr = rand_addr();
            csr_wdata = rand_bits(32);
            csr_raddr = rand_addr();
            trap = '0;
            if (rand_bits(3) == 0) begin
                random_trap();
            end
            mret = (rand_bits(3) == 0);
            if (rand_bits(3) == 0) begin
                {ext_meip, ext_mtip, ext_msip} = 3'(rand_bits(3));
            end
            tick();
        end
        end_test("mixed");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
